// File: game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// data widths
`define GAME_COORD_W        10
`define GAME_CNT_W          10
`define GAME_HP_W           8
`define GAME_SPRITE_W       12

// health bar
`define GAME_HP_START       238
`define GAME_HP_STEP        19
`define GAME_HP_FIN_LEVEL   67

// one digit glyph is this far apart on the sprite sheet
`define GAME_SPRITE_STEP    340

// red lane, notes travel down the screen
`define GAME_RED_BAD_LO     176
`define GAME_RED_BAD_HI     240
`define GAME_RED_GOOD_LO    190
`define GAME_RED_GOOD_HI    226
`define GAME_RED_PERF_LO    200
`define GAME_RED_PERF_HI    216
`define GAME_RED_MISS_AT    258

// yellow lane
`define GAME_YEL_BAD_LO     228
`define GAME_YEL_BAD_HI     292
`define GAME_YEL_GOOD_LO    242
`define GAME_YEL_GOOD_HI    278
`define GAME_YEL_PERF_LO    252
`define GAME_YEL_PERF_HI    268
`define GAME_YEL_MISS_AT    324

// green lane, notes travel up
`define GAME_GRN_BAD_LO     239
`define GAME_GRN_BAD_HI     303
`define GAME_GRN_GOOD_LO    253
`define GAME_GRN_GOOD_HI    289
`define GAME_GRN_PERF_LO    263
`define GAME_GRN_PERF_HI    279
`define GAME_GRN_MISS_AT    223

// blue lane
`define GAME_BLU_BAD_LO     347
`define GAME_BLU_BAD_HI     401
`define GAME_BLU_GOOD_LO    361
`define GAME_BLU_GOOD_HI    397
`define GAME_BLU_PERF_LO    371
`define GAME_BLU_PERF_HI    387
`define GAME_BLU_MISS_AT    317

`endif

// File: judge_pkg.sv
`default_nettype none

`include "game_defs.svh"

package judge_pkg;

    // note position on screen, x or y depending on lane
    typedef logic [`GAME_COORD_W-1:0] coord_t;

    typedef enum logic [2:0] {
        JUDGE_NONE    = 3'd0,
        JUDGE_PERFECT = 3'd1,
        JUDGE_GOOD    = 3'd2,
        JUDGE_BAD     = 3'd3,
        JUDGE_MISS    = 3'd4
    } judgment_e;

    // one lane's verdict for the cycle
    typedef struct packed {
        judgment_e grade;
        logic      remove;
    } lane_result_t;

endpackage

`default_nettype wire

// File: display_pkg.sv
`default_nettype none

`include "game_defs.svh"

package display_pkg;

    typedef logic [`GAME_CNT_W-1:0]    count_t;
    typedef logic [`GAME_HP_W-1:0]     hp_t;
    typedef logic [3:0]                digit_t;
    typedef logic [`GAME_SPRITE_W-1:0] sprite_off_t;

    typedef struct packed {
        sprite_off_t hundreds;
        sprite_off_t tens;
        sprite_off_t ones;
    } readout_t;

endpackage

`default_nettype wire

// File: lane_judge.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module lane_judge #(
    parameter judge_pkg::coord_t bad_lo  = `GAME_RED_BAD_LO,
    parameter judge_pkg::coord_t bad_hi  = `GAME_RED_BAD_HI,
    parameter judge_pkg::coord_t good_lo = `GAME_RED_GOOD_LO,
    parameter judge_pkg::coord_t good_hi = `GAME_RED_GOOD_HI,
    parameter judge_pkg::coord_t perf_lo = `GAME_RED_PERF_LO,
    parameter judge_pkg::coord_t perf_hi = `GAME_RED_PERF_HI,
    parameter judge_pkg::coord_t miss_at = `GAME_RED_MISS_AT,
    // 1: miss when position climbs to miss_at, 0: when it drops to it
    parameter bit                miss_above = 1'b1
) (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire logic                    button,
    input  wire logic                    active,
    input  wire judge_pkg::coord_t       position,
    output judge_pkg::lane_result_t      result
);

    logic in_bad;
    logic in_good;
    logic in_perf;
    logic past_line;
    logic miss_pend;

    assign in_bad  = (position >= bad_lo)  && (position <= bad_hi);
    assign in_good = (position >= good_lo) && (position <= good_hi);
    assign in_perf = (position >= perf_lo) && (position <= perf_hi);

    assign past_line = miss_above ? (position >= miss_at) : (position <= miss_at);

    //////////////////////////////
    // grading
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST) begin
            result.grade  <= judge_pkg::JUDGE_NONE;
            result.remove <= 1'b0;
            miss_pend     <= 1'b0;
        end else if (button && active && in_bad) begin
            // narrowest window wins
            if (in_perf) begin
                result.grade <= judge_pkg::JUDGE_PERFECT;
            end else if (in_good) begin
                result.grade <= judge_pkg::JUDGE_GOOD;
            end else begin
                result.grade <= judge_pkg::JUDGE_BAD;
            end
            result.remove <= 1'b1;
        end else if (!miss_pend && active && past_line) begin
            result.grade  <= judge_pkg::JUDGE_MISS;
            result.remove <= 1'b1;
            miss_pend     <= 1'b1;
        end else begin
            // idle cycle also drops the pending flag
            result.grade  <= judge_pkg::JUDGE_NONE;
            result.remove <= 1'b0;
            miss_pend     <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: score_keeper.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module score_keeper (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire judge_pkg::lane_result_t red,
    input  wire judge_pkg::lane_result_t yellow,
    input  wire judge_pkg::lane_result_t green,
    input  wire judge_pkg::lane_result_t blue,
    output display_pkg::count_t          score,
    output display_pkg::count_t          combo,
    output display_pkg::hp_t             hp,
    output logic                         finished
);

    judge_pkg::lane_result_t [3:0] lanes;

    logic any_miss;
    logic any_bad;
    logic any_good;
    logic any_perf;

    assign lanes = {blue, green, yellow, red};

    always_comb begin
        any_miss = 1'b0;
        any_bad  = 1'b0;
        any_good = 1'b0;
        any_perf = 1'b0;
        for (int i = 0; i < 4; i++) begin
            any_miss |= (lanes[i].grade == judge_pkg::JUDGE_MISS);
            any_bad  |= (lanes[i].grade == judge_pkg::JUDGE_BAD);
            any_good |= (lanes[i].grade == judge_pkg::JUDGE_GOOD);
            any_perf |= (lanes[i].grade == judge_pkg::JUDGE_PERFECT);
        end
    end

    //////////////////////////////
    // one effect per cycle
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST) begin
            score    <= '0;
            combo    <= '0;
            hp       <= display_pkg::hp_t'(`GAME_HP_START);
            finished <= 1'b0;
        end else if (any_miss) begin
            combo <= '0;
            hp    <= hp - display_pkg::hp_t'(`GAME_HP_STEP);
            // checked against the bar before this hit
            if (hp <= display_pkg::hp_t'(`GAME_HP_FIN_LEVEL)) begin
                finished <= 1'b1;
            end
        end else if (any_bad) begin
            combo <= '0;
        end else if (any_good) begin
            score <= score + display_pkg::count_t'(1);
            combo <= combo + display_pkg::count_t'(1);
        end else if (any_perf) begin
            score <= score + display_pkg::count_t'(2);
            combo <= combo + display_pkg::count_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: score_readout.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module score_readout (
    input  wire logic                 CLK,
    input  wire logic                 RST,
    input  wire display_pkg::count_t  value,
    output display_pkg::readout_t     sprites
);

    display_pkg::digit_t hundreds;
    display_pkg::digit_t tens;
    display_pkg::digit_t ones;

    // glyph offset, anything past 9 shows the zero glyph
    function automatic display_pkg::sprite_off_t glyph_off(input display_pkg::digit_t d);
        if (d <= display_pkg::digit_t'(9)) begin
            return display_pkg::sprite_off_t'(d * `GAME_SPRITE_STEP);
        end
        return '0;
    endfunction

    // 1000..1023 gives a hundreds digit of 10
    assign hundreds = display_pkg::digit_t'(value / 100);
    assign tens     = display_pkg::digit_t'((value % 100) / 10);
    assign ones     = display_pkg::digit_t'(value % 10);

    always_ff @(posedge CLK) begin
        if (RST) begin
            sprites <= '0;
        end else begin
            sprites.hundreds <= glyph_off(hundreds);
            sprites.tens     <= glyph_off(tens);
            sprites.ones     <= glyph_off(ones);
        end
    end

endmodule

`default_nettype wire

// File: rhythm_game_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

// lane bit order: 0 red, 1 yellow, 2 green, 3 blue
module rhythm_game_top (
    input  wire logic              CLK,
    input  wire logic              RST,
    input  wire logic [3:0]        buttons,
    input  wire logic [3:0]        active,
    input  wire judge_pkg::coord_t pos_red,
    input  wire judge_pkg::coord_t pos_yellow,
    input  wire judge_pkg::coord_t pos_green,
    input  wire judge_pkg::coord_t pos_blue,
    output logic [3:0]             remove,
    output display_pkg::readout_t  score_sprites,
    output display_pkg::readout_t  combo_sprites,
    output display_pkg::count_t    score_value,
    output display_pkg::count_t    combo_value,
    output display_pkg::hp_t       hp,
    output logic                   finished
);

    judge_pkg::lane_result_t red_res;
    judge_pkg::lane_result_t yellow_res;
    judge_pkg::lane_result_t green_res;
    judge_pkg::lane_result_t blue_res;

    assign remove = {blue_res.remove, green_res.remove, yellow_res.remove, red_res.remove};

    //////////////////////////////
    // lanes
    //////////////////////////////

    lane_judge #(
        .bad_lo (`GAME_RED_BAD_LO),  .bad_hi (`GAME_RED_BAD_HI),
        .good_lo(`GAME_RED_GOOD_LO), .good_hi(`GAME_RED_GOOD_HI),
        .perf_lo(`GAME_RED_PERF_LO), .perf_hi(`GAME_RED_PERF_HI),
        .miss_at(`GAME_RED_MISS_AT), .miss_above(1'b1)
    ) red_i (.CLK, .RST, .button(buttons[0]), .active(active[0]),
             .position(pos_red), .result(red_res));

    lane_judge #(
        .bad_lo (`GAME_YEL_BAD_LO),  .bad_hi (`GAME_YEL_BAD_HI),
        .good_lo(`GAME_YEL_GOOD_LO), .good_hi(`GAME_YEL_GOOD_HI),
        .perf_lo(`GAME_YEL_PERF_LO), .perf_hi(`GAME_YEL_PERF_HI),
        .miss_at(`GAME_YEL_MISS_AT), .miss_above(1'b1)
    ) yellow_i (.CLK, .RST, .button(buttons[1]), .active(active[1]),
                .position(pos_yellow), .result(yellow_res));

    // green and blue notes move toward smaller coordinates
    lane_judge #(
        .bad_lo (`GAME_GRN_BAD_LO),  .bad_hi (`GAME_GRN_BAD_HI),
        .good_lo(`GAME_GRN_GOOD_LO), .good_hi(`GAME_GRN_GOOD_HI),
        .perf_lo(`GAME_GRN_PERF_LO), .perf_hi(`GAME_GRN_PERF_HI),
        .miss_at(`GAME_GRN_MISS_AT), .miss_above(1'b0)
    ) green_i (.CLK, .RST, .button(buttons[2]), .active(active[2]),
               .position(pos_green), .result(green_res));

    lane_judge #(
        .bad_lo (`GAME_BLU_BAD_LO),  .bad_hi (`GAME_BLU_BAD_HI),
        .good_lo(`GAME_BLU_GOOD_LO), .good_hi(`GAME_BLU_GOOD_HI),
        .perf_lo(`GAME_BLU_PERF_LO), .perf_hi(`GAME_BLU_PERF_HI),
        .miss_at(`GAME_BLU_MISS_AT), .miss_above(1'b0)
    ) blue_i (.CLK, .RST, .button(buttons[3]), .active(active[3]),
              .position(pos_blue), .result(blue_res));

    //////////////////////////////
    // scoring and display
    //////////////////////////////

    score_keeper keeper_i (
        .CLK, .RST,
        .red(red_res), .yellow(yellow_res), .green(green_res), .blue(blue_res),
        .score(score_value), .combo(combo_value), .hp(hp), .finished(finished)
    );

    score_readout score_ro_i (.CLK, .RST, .value(score_value), .sprites(score_sprites));
    score_readout combo_ro_i (.CLK, .RST, .value(combo_value), .sprites(combo_sprites));

endmodule

`default_nettype wire

// File: game_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module game_asserts (
    input wire logic                    CLK,
    input wire logic                    RST,
    input wire logic [3:0]              remove,
    input wire judge_pkg::lane_result_t red_res,
    input wire judge_pkg::lane_result_t yellow_res,
    input wire judge_pkg::lane_result_t green_res,
    input wire judge_pkg::lane_result_t blue_res,
    input wire display_pkg::hp_t        hp,
    input wire logic                    finished
);

    logic [3:0] graded;
    logic       any_miss;

    assign graded = {blue_res.grade != judge_pkg::JUDGE_NONE,
                     green_res.grade != judge_pkg::JUDGE_NONE,
                     yellow_res.grade != judge_pkg::JUDGE_NONE,
                     red_res.grade != judge_pkg::JUDGE_NONE};

    assign any_miss = (red_res.grade == judge_pkg::JUDGE_MISS)
                   || (yellow_res.grade == judge_pkg::JUDGE_MISS)
                   || (green_res.grade == judge_pkg::JUDGE_MISS)
                   || (blue_res.grade == judge_pkg::JUDGE_MISS);

    remove_has_grade: assert property (@(posedge CLK) disable iff (RST)
        (remove & ~graded) == 4'b0)
        else $error("remove strobe without a grade on that lane");

    finished_sticks: assert property (@(posedge CLK) disable iff (RST)
        finished |=> finished)
        else $error("finished flag fell");

    // health only moves on the edge right after a miss
    hp_moves_on_miss: assert property (@(posedge CLK) disable iff (RST)
        (hp != $past(hp)) |-> $past(any_miss))
        else $error("hp changed without a miss");

endmodule

bind rhythm_game_top game_asserts asserts_i (
    .CLK(CLK), .RST(RST), .remove(remove),
    .red_res(red_res), .yellow_res(yellow_res), .green_res(green_res), .blue_res(blue_res),
    .hp(hp), .finished(finished)
);

`default_nettype wire

// File: tb_rhythm_game.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defs.svh"

module tb_rhythm_game;

    localparam int NUM_VEC     = 23;
    localparam int FIELDS      = 12;
    localparam int REMOVE_WAIT = 8;

    logic                  CLK;
    logic                  RST;
    logic [3:0]            buttons;
    logic [3:0]            active;
    judge_pkg::coord_t     pos_red;
    judge_pkg::coord_t     pos_yellow;
    judge_pkg::coord_t     pos_green;
    judge_pkg::coord_t     pos_blue;
    logic [3:0]            remove;
    display_pkg::readout_t score_sprites;
    display_pkg::readout_t combo_sprites;
    display_pkg::count_t   score_value;
    display_pkg::count_t   combo_value;
    display_pkg::hp_t      hp;
    logic                  finished;

    // FIELDS words per vector in file column order
    logic [11:0] vec_mem [0:NUM_VEC*FIELDS-1];
    int unsigned seed_draw;

    rhythm_game_top dut_i (.*);

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_count(input display_pkg::count_t got, input display_pkg::count_t exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_hp(input display_pkg::hp_t got, input display_pkg::hp_t exp,
                            input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_sprite(input display_pkg::sprite_off_t got,
                                input display_pkg::sprite_off_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // a hundreds digit of 10 shows the zero glyph
    function automatic display_pkg::readout_t sprites_for(input display_pkg::count_t v);
        int h;
        int t;
        int o;
        display_pkg::readout_t r;
        h = v / 100;
        t = (v / 10) % 10;
        o = v % 10;
        r.hundreds = (h < 10) ? display_pkg::sprite_off_t'(h * `GAME_SPRITE_STEP) : '0;
        r.tens     = display_pkg::sprite_off_t'(t * `GAME_SPRITE_STEP);
        r.ones     = display_pkg::sprite_off_t'(o * `GAME_SPRITE_STEP);
        return r;
    endfunction

    task automatic check_readout(input display_pkg::readout_t got,
                                 input display_pkg::count_t value, input string what);
        display_pkg::readout_t exp;
        exp = sprites_for(value);
        check_sprite(got.hundreds, exp.hundreds, {what, " hundreds"});
        check_sprite(got.tens, exp.tens, {what, " tens"});
        check_sprite(got.ones, exp.ones, {what, " ones"});
    endtask

    function automatic logic [11:0] vec_field(input int v, input int col);
        return vec_mem[v*FIELDS + col];
    endfunction

    //////////////////////////////
    // vector replay
    //////////////////////////////

    task automatic run_vector(input int v);
        int         rep;
        int         waited;
        logic [3:0] exp_remove;
        rep        = vec_field(v, 0);
        exp_remove = 4'(vec_field(v, 7));
        for (int r = 0; r < rep; r++) begin
            repeat (seed_draw % 4) @(posedge CLK);
            seed_draw = $urandom;
            @(posedge CLK);
            #1;
            buttons    = 4'(vec_field(v, 1));
            active     = 4'(vec_field(v, 2));
            pos_red    = judge_pkg::coord_t'(vec_field(v, 3));
            pos_yellow = judge_pkg::coord_t'(vec_field(v, 4));
            pos_green  = judge_pkg::coord_t'(vec_field(v, 5));
            pos_blue   = judge_pkg::coord_t'(vec_field(v, 6));
            @(posedge CLK);
            #1;
            // note is gone once removed
            buttons = 4'b0;
            active  = 4'b0;
            waited  = 0;
            while (exp_remove != 4'b0 && remove == 4'b0) begin
                if (waited == REMOVE_WAIT) begin
                    fail_run($sformatf("no remove pulse came for vector %0d", v));
                end
                @(posedge CLK);
                #1;
                waited++;
            end
            for (int i = 0; i < 4; i++) begin
                check_bit(remove[i], exp_remove[i], $sformatf("remove[%0d] vec %0d", i, v));
            end
            repeat (2) @(posedge CLK);
            #1;
        end
        check_count(score_value, display_pkg::count_t'(vec_field(v, 8)), "score");
        check_count(combo_value, display_pkg::count_t'(vec_field(v, 9)), "combo");
        check_hp(hp, display_pkg::hp_t'(vec_field(v, 10)), "hp");
        check_bit(finished, 1'(vec_field(v, 11)), "finished");
        check_readout(score_sprites, display_pkg::count_t'(vec_field(v, 8)), "score sprite");
        check_readout(combo_sprites, display_pkg::count_t'(vec_field(v, 9)), "combo sprite");
    endtask

    initial begin
        seed_draw  = $urandom(32'h65ca_313e);
        RST        = 1'b1;
        buttons    = 4'b0;
        active     = 4'b0;
        pos_red    = '0;
        pos_yellow = '0;
        pos_green  = '0;
        pos_blue   = '0;
        $readmemh("game_testdata.txt", vec_mem);
        repeat (5) @(posedge CLK);
        #1;
        RST = 1'b0;
        check_count(score_value, '0, "score after reset");
        check_count(combo_value, '0, "combo after reset");
        check_hp(hp, display_pkg::hp_t'(`GAME_HP_START), "hp after reset");
        check_bit(finished, 1'b0, "finished after reset");
        check_readout(score_sprites, '0, "score sprite after reset");
        check_readout(combo_sprites, '0, "combo sprite after reset");
        for (int v = 0; v < NUM_VEC; v++) begin
            run_vector(v);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: game_testdata.txt
// rep btn act pos_r pos_y pos_g pos_b | remove score combo hp fin, all hex
// lane bits 0 red 1 yellow 2 green 3 blue
01 1 1 0D0 000 000 000 1 002 001 EE 0
01 1 1 0C3 000 000 000 1 003 002 EE 0
01 1 1 0B4 000 000 000 1 003 000 EE 0
01 2 2 000 104 000 000 2 005 001 EE 0
01 2 2 000 0F5 000 000 2 006 002 EE 0
01 2 2 000 11D 000 000 2 006 000 EE 0
01 4 4 000 000 10E 000 4 008 001 EE 0
01 4 4 000 000 0FF 000 4 009 002 EE 0
01 4 4 000 000 12C 000 4 009 000 EE 0
01 8 8 000 000 000 17C 8 00B 001 EE 0
01 8 8 000 000 000 18B 8 00C 002 EE 0
01 8 8 000 000 000 15E 8 00C 000 EE 0
01 0 1 104 000 000 000 1 00C 000 DB 0
01 0 2 000 14A 000 000 2 00C 000 C8 0
01 0 4 000 000 0DC 000 4 00C 000 B5 0
01 0 8 000 000 000 136 8 00C 000 A2 0
01 3 3 0C3 104 000 000 3 00D 001 A2 0
01 2 3 104 104 000 000 3 00D 000 8F 0
04 0 1 104 000 000 000 1 00D 000 43 0
01 0 1 104 000 000 000 1 00D 000 30 1
0A 1 1 0D0 000 000 000 1 021 00A 30 1
01 1 1 0B4 000 000 000 1 021 000 30 1
2D 2 2 000 104 000 000 2 07B 02D 30 1

// File: verilog.f
+incdir+.
judge_pkg.sv
display_pkg.sv
lane_judge.sv
score_keeper.sv
score_readout.sv
rhythm_game_top.sv
game_asserts.sv
tb_rhythm_game.sv

// File: Bender.yml
package:
  name: rhythm_game

export_include_dirs:
  - .

sources:
  - judge_pkg.sv
  - display_pkg.sv
  - lane_judge.sv
  - score_keeper.sv
  - score_readout.sv
  - rhythm_game_top.sv
  - target: test
    files:
      - game_asserts.sv
      - tb_rhythm_game.sv
